//--- logic/ctl_defs.svh
/*
 * RDMA register sequencer
 * Bus widths, poll limit and the consumer doorbell marker
 */
`ifndef CTL_DEFS_SVH
`define CTL_DEFS_SVH

`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// Doorbell reads allowed in one completion check
`define RQ_POLL_LIMIT 1024

// Golden value that selects a consumer doorbell write
`define CIDB_MARKER {`AXIL_DATA_W{1'b1}}

`endif

//--- logic/axil_pkg.sv
/*
 * AXI-Lite master channel bundles and response codes
 */
`default_nettype none
`include "ctl_defs.svh"

package axil_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  // Write address, write data and B ready, driven by the master
  typedef struct packed {
    logic                    awvalid;
    logic [`AXIL_ADDR_W-1:0] awaddr;
    logic                    wvalid;
    logic [`AXIL_DATA_W-1:0] wdata;
    logic                    bready;
  } axil_wr_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_e bresp;
  } axil_wr_rsp_t;

  typedef struct packed {
    logic                    arvalid;
    logic [`AXIL_ADDR_W-1:0] araddr;
    logic                    rready;
  } axil_rd_req_t;

  typedef struct packed {
    logic                    arready;
    logic                    rvalid;
    logic [`AXIL_DATA_W-1:0] rdata;
    axil_resp_e              rresp;
  } axil_rd_rsp_t;

endpackage

`default_nettype wire

//--- logic/rdma_ctl_pkg.sv
/*
 * RDMA register sequencer command and bus-operation types
 */
`default_nettype none
`include "ctl_defs.svh"

package rdma_ctl_pkg;

  typedef enum logic [1:0] {
    OP_CFG_WRITE = 2'd0,
    OP_STAT_READ = 2'd1,
    OP_RQ_CHECK  = 2'd2
  } cmd_op_e;

  // One data word, meaning depends on the opcode
  typedef union packed {
    logic [`AXIL_DATA_W-1:0] wdata;
    logic [`AXIL_DATA_W-1:0] golden;
  } reg_payload_u;

  typedef struct packed {
    cmd_op_e                 op;
    logic [`AXIL_ADDR_W-1:0] addr;
    reg_payload_u            payload;
  } reg_cmd_t;

  typedef enum logic [1:0] {
    KIND_CFG  = 2'd0,
    KIND_STAT = 2'd1,
    KIND_PIDB = 2'd2,
    KIND_CIDB = 2'd3
  } bus_kind_e;

  // A single bus access and how its response is judged
  typedef struct packed {
    bus_kind_e               kind;
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`AXIL_DATA_W-1:0] wdata;
    logic [`AXIL_DATA_W-1:0] golden;
  } bus_op_t;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`AXIL_DATA_W-1:0] value;
  } stat_result_t;

endpackage

`default_nettype wire

//--- logic/cmd_decode.sv
/*
 * Command decode stage
 * Accepts one command, holds busy and issues its bus operation,
 * reissuing it whenever the response stage asks for another poll
 */
`timescale 1ns/1ps
`default_nettype none
`include "ctl_defs.svh"

module cmd_decode (
  input  wire                           axil_clk,
  input  wire                           axil_rstn,
  input  wire                           cmd_vld,
  input  wire rdma_ctl_pkg::reg_cmd_t   cmd,
  output logic                          busy,
  input  wire                           retry,
  input  wire                           op_done,
  input  wire [`AXIL_DATA_W-1:0]        pidb_value,
  output logic                          issue_vld,
  output rdma_ctl_pkg::bus_op_t         issue_op
);
  import rdma_ctl_pkg::*;

  reg_cmd_t cmd_q;
  logic     accept;

  assign accept = cmd_vld && !busy;

  always_ff @(posedge axil_clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      busy      <= 1'b0;
      issue_vld <= 1'b0;
    end else begin
      issue_vld <= accept || retry;
      if (accept) begin
        busy <= 1'b1;
      end else if (op_done) begin
        busy <= 1'b0;
      end
    end
  end

  // ==============================
  // Payload decode
  // ==============================
  always_comb begin
    issue_op.addr   = cmd_q.addr;
    issue_op.wdata  = cmd_q.payload.wdata;
    issue_op.golden = cmd_q.payload.golden;
    case (cmd_q.op)
      OP_CFG_WRITE: issue_op.kind = KIND_CFG;
      OP_STAT_READ: issue_op.kind = KIND_STAT;
      default: begin
        if (cmd_q.payload.golden == `CIDB_MARKER) begin
          // Consumer doorbell takes the last producer value seen
          issue_op.kind  = KIND_CIDB;
          issue_op.wdata = pidb_value;
        end else begin
          issue_op.kind = KIND_PIDB;
        end
      end
    endcase
  end

  a_no_cmd_while_busy: assert property (@(posedge axil_clk) disable iff (!axil_rstn)
    cmd_vld |-> !busy);

endmodule

`default_nettype wire

//--- logic/axil_write_engine.sv
/*
 * AXI-Lite write engine
 * Runs the AW, W and B phases of one write in turn
 */
`timescale 1ns/1ps
`default_nettype none
`include "ctl_defs.svh"

module axil_write_engine (
  input  wire                           axil_clk,
  input  wire                           axil_rstn,
  input  wire                           issue_vld,
  input  wire rdma_ctl_pkg::bus_op_t    issue_op,
  output axil_pkg::axil_wr_req_t        wr_req,
  input  wire axil_pkg::axil_wr_rsp_t   wr_rsp,
  output logic                          wr_done,
  output axil_pkg::axil_resp_e          wr_resp
);
  import axil_pkg::*;
  import rdma_ctl_pkg::*;

  typedef enum logic [1:0] {WR_IDLE, WR_AW, WR_W, WR_B} wr_state_e;

  wr_state_e               state;
  logic [`AXIL_ADDR_W-1:0] addr_q;
  logic [`AXIL_DATA_W-1:0] data_q;
  logic                    start;

  assign start = issue_vld && (state == WR_IDLE) &&
                 ((issue_op.kind == KIND_CFG) || (issue_op.kind == KIND_CIDB));

  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      state   <= WR_IDLE;
      wr_done <= 1'b0;
    end else begin
      wr_done <= 1'b0;
      case (state)
        WR_IDLE: if (start) state <= WR_AW;
        WR_AW:   if (wr_rsp.awready) state <= WR_W;
        WR_W:    if (wr_rsp.wready) state <= WR_B;
        WR_B: begin
          if (wr_rsp.bvalid) begin
            state   <= WR_IDLE;
            wr_done <= 1'b1;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge axil_clk) begin
    if (start) begin
      addr_q <= issue_op.addr;
      data_q <= issue_op.wdata;
    end
    if ((state == WR_B) && wr_rsp.bvalid) begin
      wr_resp <= wr_rsp.bresp;
    end
  end

  // Valid held from state, payload from the capture registers
  always_comb begin
    wr_req.awvalid = (state == WR_AW);
    wr_req.awaddr  = addr_q;
    wr_req.wvalid  = (state == WR_W);
    wr_req.wdata   = data_q;
    wr_req.bready  = (state == WR_B);
  end

  a_aw_stable: assert property (@(posedge axil_clk) disable iff (!axil_rstn)
    wr_req.awvalid && !wr_rsp.awready |=> wr_req.awvalid && $stable(wr_req.awaddr));
  a_w_stable: assert property (@(posedge axil_clk) disable iff (!axil_rstn)
    wr_req.wvalid && !wr_rsp.wready |=> wr_req.wvalid && $stable(wr_req.wdata));

endmodule

`default_nettype wire

//--- logic/axil_read_engine.sv
/*
 * AXI-Lite read engine
 * Runs the AR and R phases of one read and captures the data
 */
`timescale 1ns/1ps
`default_nettype none
`include "ctl_defs.svh"

module axil_read_engine (
  input  wire                           axil_clk,
  input  wire                           axil_rstn,
  input  wire                           issue_vld,
  input  wire rdma_ctl_pkg::bus_op_t    issue_op,
  output axil_pkg::axil_rd_req_t        rd_req,
  input  wire axil_pkg::axil_rd_rsp_t   rd_rsp,
  output logic                          rd_done,
  output axil_pkg::axil_resp_e          rd_resp,
  output logic [`AXIL_DATA_W-1:0]       rd_data
);
  import axil_pkg::*;
  import rdma_ctl_pkg::*;

  typedef enum logic [1:0] {RD_IDLE, RD_AR, RD_R} rd_state_e;

  rd_state_e               state;
  logic [`AXIL_ADDR_W-1:0] addr_q;
  logic                    start;

  assign start = issue_vld && (state == RD_IDLE) &&
                 ((issue_op.kind == KIND_STAT) || (issue_op.kind == KIND_PIDB));

  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      state   <= RD_IDLE;
      rd_done <= 1'b0;
    end else begin
      rd_done <= 1'b0;
      case (state)
        RD_IDLE: if (start) state <= RD_AR;
        RD_AR:   if (rd_rsp.arready) state <= RD_R;
        RD_R: begin
          if (rd_rsp.rvalid) begin
            state   <= RD_IDLE;
            rd_done <= 1'b1;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge axil_clk) begin
    if (start) begin
      addr_q <= issue_op.addr;
    end
    // Capture on the R handshake
    if ((state == RD_R) && rd_rsp.rvalid) begin
      rd_data <= rd_rsp.rdata;
      rd_resp <= rd_rsp.rresp;
    end
  end

  always_comb begin
    rd_req.arvalid = (state == RD_AR);
    rd_req.araddr  = addr_q;
    rd_req.rready  = (state == RD_R);
  end

  a_ar_stable: assert property (@(posedge axil_clk) disable iff (!axil_rstn)
    rd_req.arvalid && !rd_rsp.arready |=> rd_req.arvalid && $stable(rd_req.araddr));

endmodule

`default_nettype wire

//--- logic/response_stage.sv
/*
 * Response stage
 * Judges each bus response, reissues doorbell polls up to the limit
 * and forms the completion, statistics and error pulses
 */
`timescale 1ns/1ps
`default_nettype none
`include "ctl_defs.svh"

module response_stage (
  input  wire                           axil_clk,
  input  wire                           axil_rstn,
  input  wire                           issue_vld,
  input  wire rdma_ctl_pkg::bus_op_t    issue_op,
  input  wire                           wr_done,
  input  wire axil_pkg::axil_resp_e     wr_resp,
  input  wire                           rd_done,
  input  wire axil_pkg::axil_resp_e     rd_resp,
  input  wire [`AXIL_DATA_W-1:0]        rd_data,
  output logic                          retry,
  output logic                          op_done,
  output logic                          stat_vld,
  output logic                          rq_timeout,
  output logic                          resp_err,
  output rdma_ctl_pkg::stat_result_t    stat,
  output logic [`AXIL_DATA_W-1:0]       pidb_value
);
  import axil_pkg::*;
  import rdma_ctl_pkg::*;

  localparam int CNT_W = $clog2(`RQ_POLL_LIMIT) + 1;

  bus_op_t          op_q;
  logic [CNT_W-1:0] poll_cnt;
  logic             done;
  axil_resp_e       resp;
  logic             last_poll;
  logic             match;

  assign done      = wr_done || rd_done;
  assign resp      = wr_done ? wr_resp : rd_resp;
  assign last_poll = (poll_cnt == CNT_W'(`RQ_POLL_LIMIT - 1));
  assign match     = (rd_data == op_q.golden);

  always_ff @(posedge axil_clk) begin
    if (issue_vld) begin
      op_q <= issue_op;
    end
    if (rd_done) begin
      stat.addr  <= op_q.addr;
      stat.value <= rd_data;
    end
  end

  // ==============================
  // Verdict per bus response
  // ==============================
  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      retry      <= 1'b0;
      op_done    <= 1'b0;
      stat_vld   <= 1'b0;
      rq_timeout <= 1'b0;
      resp_err   <= 1'b0;
      poll_cnt   <= '0;
      pidb_value <= '0;
    end else begin
      retry      <= 1'b0;
      op_done    <= 1'b0;
      stat_vld   <= 1'b0;
      rq_timeout <= 1'b0;
      resp_err   <= 1'b0;
      if (done && (resp != OKAY)) begin
        op_done  <= 1'b1;
        resp_err <= 1'b1;
        poll_cnt <= '0;
      end else if (done) begin
        case (op_q.kind)
          KIND_STAT: begin
            op_done  <= 1'b1;
            stat_vld <= 1'b1;
          end
          KIND_PIDB: begin
            pidb_value <= rd_data;
            if (match || last_poll) begin
              op_done    <= 1'b1;
              rq_timeout <= !match;
              poll_cnt   <= '0;
            end else begin
              retry    <= 1'b1;
              poll_cnt <= poll_cnt + 1'b1;
            end
          end
          default: op_done <= 1'b1;
        endcase
      end
    end
  end

  a_retry_or_done: assert property (@(posedge axil_clk) disable iff (!axil_rstn)
    retry |-> !op_done);

endmodule

`default_nettype wire

//--- logic/rdma_reg_sequencer.sv
/*
 * RDMA AXI-Lite register sequencer
 * Decode, bus engines and response stage for one command at a time
 */
`timescale 1ns/1ps
`default_nettype none
`include "ctl_defs.svh"

module rdma_reg_sequencer (
  input  wire                           axil_clk,
  input  wire                           axil_rstn,
  input  wire                           cmd_vld,
  input  wire rdma_ctl_pkg::reg_cmd_t   cmd,
  output logic                          busy,
  output logic                          op_done,
  output logic                          stat_vld,
  output logic                          rq_timeout,
  output logic                          resp_err,
  output rdma_ctl_pkg::stat_result_t    stat,
  output axil_pkg::axil_wr_req_t        wr_req,
  input  wire axil_pkg::axil_wr_rsp_t   wr_rsp,
  output axil_pkg::axil_rd_req_t        rd_req,
  input  wire axil_pkg::axil_rd_rsp_t   rd_rsp
);
  import axil_pkg::*;
  import rdma_ctl_pkg::*;

  logic                    issue_vld;
  bus_op_t                 issue_op;
  logic                    retry;
  logic [`AXIL_DATA_W-1:0] pidb_value;
  logic                    wr_done;
  axil_resp_e              wr_resp;
  logic                    rd_done;
  axil_resp_e              rd_resp;
  logic [`AXIL_DATA_W-1:0] rd_data;

  cmd_decode u_decode (
    .axil_clk, .axil_rstn, .cmd_vld, .cmd, .busy,
    .retry, .op_done, .pidb_value, .issue_vld, .issue_op
  );

  axil_write_engine u_wr (
    .axil_clk, .axil_rstn, .issue_vld, .issue_op,
    .wr_req, .wr_rsp, .wr_done, .wr_resp
  );

  axil_read_engine u_rd (
    .axil_clk, .axil_rstn, .issue_vld, .issue_op,
    .rd_req, .rd_rsp, .rd_done, .rd_resp, .rd_data
  );

  response_stage u_resp (
    .axil_clk, .axil_rstn, .issue_vld, .issue_op,
    .wr_done, .wr_resp, .rd_done, .rd_resp, .rd_data,
    .retry, .op_done, .stat_vld, .rq_timeout, .resp_err,
    .stat, .pidb_value
  );

endmodule

`default_nettype wire

//--- bench/axil_slave_model.sv
/*
 * AXI-Lite slave model
 * 64-word register memory, a doorbell that counts up on every read,
 * one address that answers SLVERR, and a backdoor preset port
 */
`timescale 1ns/1ps
`default_nettype none
`include "ctl_defs.svh"

module axil_slave_model #(
  parameter logic [`AXIL_ADDR_W-1:0] PIDB_ADDR = 32'h200,
  parameter logic [`AXIL_ADDR_W-1:0] ERR_ADDR  = 32'h300
) (
  input  wire                           axil_clk,
  input  wire                           axil_rstn,
  input  wire axil_pkg::axil_wr_req_t   wr_req,
  output axil_pkg::axil_wr_rsp_t        wr_rsp,
  input  wire axil_pkg::axil_rd_req_t   rd_req,
  output axil_pkg::axil_rd_rsp_t        rd_rsp,
  input  wire                           bd_en,
  input  wire [`AXIL_ADDR_W-1:0]        bd_addr,
  input  wire [`AXIL_DATA_W-1:0]        bd_data,
  output logic [31:0]                   db_reads
);
  import axil_pkg::*;

  logic [`AXIL_DATA_W-1:0] mem [0:63];
  logic [`AXIL_DATA_W-1:0] db_reg;
  logic [1:0]              aw_wait;
  logic [1:0]              w_wait;
  logic [1:0]              ar_wait;

  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      wr_rsp   <= '0;
      rd_rsp   <= '0;
      aw_wait  <= 2'd0;
      w_wait   <= 2'd0;
      ar_wait  <= 2'd0;
      db_reg   <= '0;
      db_reads <= '0;
    end else begin
      // Each ready comes after a random wait while its valid is up
      if (wr_req.awvalid && !wr_rsp.awready) begin
        if (aw_wait == 2'd0) wr_rsp.awready <= 1'b1;
        else aw_wait <= aw_wait - 2'd1;
      end else begin
        wr_rsp.awready <= 1'b0;
        aw_wait        <= 2'($urandom % 4);
      end
      if (wr_req.wvalid && !wr_rsp.wready) begin
        if (w_wait == 2'd0) wr_rsp.wready <= 1'b1;
        else w_wait <= w_wait - 2'd1;
      end else begin
        wr_rsp.wready <= 1'b0;
        w_wait        <= 2'($urandom % 4);
      end
      if (rd_req.arvalid && !rd_rsp.arready) begin
        if (ar_wait == 2'd0) rd_rsp.arready <= 1'b1;
        else ar_wait <= ar_wait - 2'd1;
      end else begin
        rd_rsp.arready <= 1'b0;
        ar_wait        <= 2'($urandom % 4);
      end

      // ==============================
      // Write and read data paths
      // ==============================
      if (wr_rsp.bvalid && wr_req.bready) wr_rsp.bvalid <= 1'b0;
      if (wr_req.wvalid && wr_rsp.wready) begin
        wr_rsp.bvalid <= 1'b1;
        wr_rsp.bresp  <= (wr_req.awaddr == ERR_ADDR) ? SLVERR : OKAY;
        if (wr_req.awaddr != ERR_ADDR) mem[wr_req.awaddr[7:2]] <= wr_req.wdata;
      end
      if (rd_rsp.rvalid && rd_req.rready) rd_rsp.rvalid <= 1'b0;
      if (rd_req.arvalid && rd_rsp.arready) begin
        rd_rsp.rvalid <= 1'b1;
        rd_rsp.rresp  <= (rd_req.araddr == ERR_ADDR) ? SLVERR : OKAY;
        if (rd_req.araddr == PIDB_ADDR) begin
          rd_rsp.rdata <= db_reg;
          db_reg       <= db_reg + 1'b1;
          db_reads     <= db_reads + 1;
        end else if (rd_req.araddr == ERR_ADDR) begin
          rd_rsp.rdata <= '0;
        end else begin
          rd_rsp.rdata <= mem[rd_req.araddr[7:2]];
        end
      end

      // Backdoor preset, doorbell address also clears the read count
      if (bd_en) begin
        if (bd_addr == PIDB_ADDR) begin
          db_reg   <= bd_data;
          db_reads <= '0;
        end else begin
          mem[bd_addr[7:2]] <= bd_data;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_rdma_reg_sequencer.sv
/*
 * Testbench for the RDMA register sequencer
 * Directed tests for writes, reads, doorbell polling, timeout and errors
 */
`timescale 1ns/1ps
`default_nettype none
`include "ctl_defs.svh"

module tb_rdma_reg_sequencer;
  import axil_pkg::*;
  import rdma_ctl_pkg::*;

  localparam logic [31:0] PIDB_ADDR = 32'h200;
  localparam logic [31:0] ERR_ADDR  = 32'h300;
  localparam logic [31:0] CIDB_ADDR = 32'h80;
  // About 12 cycles per bus access, the poll limit dominates
  localparam int TIMEOUT_CYCLES = (`RQ_POLL_LIMIT + 64) * 12 + 500;

  logic         axil_clk = 1'b0;
  logic         axil_rstn;
  logic         cmd_vld;
  reg_cmd_t     cmd;
  logic         busy;
  logic         op_done;
  logic         stat_vld;
  logic         rq_timeout;
  logic         resp_err;
  stat_result_t stat;
  axil_wr_req_t wr_req;
  axil_wr_rsp_t wr_rsp;
  axil_rd_req_t rd_req;
  axil_rd_rsp_t rd_rsp;
  logic         bd_en;
  logic [31:0]  bd_addr;
  logic [31:0]  bd_data;
  logic [31:0]  db_reads;

  int           cycles = 0;
  int           errors = 0;
  int           seed_val;
  int           stat_count = 0;
  int           aw_count = 0;
  int           ar_count = 0;
  stat_result_t res_stat;
  logic         res_timeout;
  logic         res_err;
  int           res_stat_cnt;
  int           res_aw;
  int           res_ar;

  rdma_reg_sequencer dut0 (
    .axil_clk, .axil_rstn, .cmd_vld, .cmd, .busy,
    .op_done, .stat_vld, .rq_timeout, .resp_err, .stat,
    .wr_req, .wr_rsp, .rd_req, .rd_rsp
  );

  axil_slave_model #(.PIDB_ADDR(PIDB_ADDR), .ERR_ADDR(ERR_ADDR)) slave0 (
    .axil_clk, .axil_rstn, .wr_req, .wr_rsp, .rd_req, .rd_rsp,
    .bd_en, .bd_addr, .bd_data, .db_reads
  );

  always #10 axil_clk = ~axil_clk;

  // Handshakes and result pulses, counted where they are stable
  always @(negedge axil_clk) begin
    if (stat_vld) stat_count <= stat_count + 1;
    if (wr_req.awvalid && wr_rsp.awready) aw_count <= aw_count + 1;
    if (rd_req.arvalid && rd_rsp.arready) ar_count <= ar_count + 1;
  end

  always @(posedge axil_clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout: no completion within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $fatal(1);
    end
  end

  task automatic stop_run();
    errors++;
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic preload(input logic [31:0] addr, input logic [31:0] data);
    bd_addr = addr;
    bd_data = data;
    bd_en   = 1'b1;
    @(negedge axil_clk);
    bd_en   = 1'b0;
  endtask

  // Issues one command and waits for op_done, busy must drop one cycle later
  task automatic run_cmd(input cmd_op_e op, input logic [31:0] addr, input logic [31:0] word);
    int stat_before;
    int aw_before;
    int ar_before;
    while (busy) @(negedge axil_clk);
    stat_before = stat_count;
    aw_before   = aw_count;
    ar_before   = ar_count;
    cmd.op      = op;
    cmd.addr    = addr;
    if (op == OP_RQ_CHECK) cmd.payload.golden = word;
    else cmd.payload.wdata = word;
    cmd_vld = 1'b1;
    @(negedge axil_clk);
    cmd_vld = 1'b0;
    while (!op_done) @(negedge axil_clk);
    res_stat    = stat;
    res_timeout = rq_timeout;
    res_err     = resp_err;
    check_eq("busy", busy, 1);
    @(negedge axil_clk);
    check_eq("busy", busy, 0);
    res_stat_cnt = stat_count - stat_before;
    res_aw       = aw_count - aw_before;
    res_ar       = ar_count - ar_before;
  endtask

  task automatic test_cfg_write();
    logic [31:0] addr_list [8];
    logic [31:0] data_list [8];
    for (int i = 0; i < 8; i++) begin
      addr_list[i] = 32'h40 + 32'(i) * 4;
      data_list[i] = $urandom;
      run_cmd(OP_CFG_WRITE, addr_list[i], data_list[i]);
      check_eq("resp_err", res_err, 0);
      check_eq("aw handshakes", res_aw, 1);
    end
    for (int i = 0; i < 8; i++) begin
      run_cmd(OP_STAT_READ, addr_list[i], 32'h0);
      check_eq("stat.addr", res_stat.addr, addr_list[i]);
      check_eq("stat.value", res_stat.value, data_list[i]);
    end
  endtask

  task automatic test_stat_preload();
    logic [31:0] addr;
    for (int i = 0; i < 4; i++) begin
      addr = 32'h10 + 32'(i) * 4;
      preload(addr, addr ^ 32'hA5C3_0F1E);
    end
    for (int i = 0; i < 4; i++) begin
      addr = 32'h10 + 32'(i) * 4;
      run_cmd(OP_STAT_READ, addr, 32'h0);
      check_eq("stat_vld pulses", res_stat_cnt, 1);
      check_eq("stat.value", res_stat.value, addr ^ 32'hA5C3_0F1E);
    end
  endtask

  task automatic test_rq_match();
    logic [31:0] golden;
    golden = $urandom & 32'h0FFF_FFFF;
    preload(PIDB_ADDR, golden);
    run_cmd(OP_RQ_CHECK, PIDB_ADDR, golden);
    check_eq("rq_timeout", res_timeout, 0);
    check_eq("doorbell reads", db_reads, 1);
  endtask

  task automatic test_rq_poll();
    logic [31:0] golden;
    int          k;
    golden = $urandom & 32'h0FFF_FFFF;
    k      = 5;
    preload(PIDB_ADDR, golden - k);
    run_cmd(OP_RQ_CHECK, PIDB_ADDR, golden);
    check_eq("rq_timeout", res_timeout, 0);
    check_eq("doorbell reads", db_reads, k + 1);
    // Marker golden writes the captured producer value to the consumer doorbell
    run_cmd(OP_RQ_CHECK, CIDB_ADDR, `CIDB_MARKER);
    check_eq("resp_err", res_err, 0);
    run_cmd(OP_STAT_READ, CIDB_ADDR, 32'h0);
    check_eq("cidb value", res_stat.value, golden);
  endtask

  task automatic test_rq_timeout();
    logic [31:0] golden;
    golden = $urandom & 32'h0FFF_FFFF;
    preload(PIDB_ADDR, golden + 1);
    run_cmd(OP_RQ_CHECK, PIDB_ADDR, golden);
    check_eq("rq_timeout", res_timeout, 1);
    check_eq("doorbell reads", db_reads, `RQ_POLL_LIMIT);
  endtask

  task automatic test_err_resp();
    run_cmd(OP_CFG_WRITE, ERR_ADDR, 32'h1234_5678);
    check_eq("resp_err", res_err, 1);
    check_eq("aw handshakes", res_aw, 1);
    run_cmd(OP_STAT_READ, ERR_ADDR, 32'h0);
    check_eq("resp_err", res_err, 1);
    check_eq("stat_vld pulses", res_stat_cnt, 0);
    check_eq("ar handshakes", res_ar, 1);
    run_cmd(OP_RQ_CHECK, ERR_ADDR, 32'h5);
    check_eq("resp_err", res_err, 1);
    check_eq("rq_timeout", res_timeout, 0);
    check_eq("ar handshakes", res_ar, 1);
  endtask

  initial begin
    seed_val  = $urandom(94);
    axil_rstn = 1'b0;
    cmd_vld   = 1'b0;
    cmd       = '0;
    bd_en     = 1'b0;
    bd_addr   = '0;
    bd_data   = '0;
    repeat (2) @(negedge axil_clk);
    axil_rstn = 1'b1;
    @(negedge axil_clk);
    test_cfg_write();
    test_stat_preload();
    test_rq_match();
    test_rq_poll();
    test_rq_timeout();
    test_err_resp();
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+logic
logic/axil_pkg.sv
logic/rdma_ctl_pkg.sv
logic/cmd_decode.sv
logic/axil_write_engine.sv
logic/axil_read_engine.sv
logic/response_stage.sv
logic/rdma_reg_sequencer.sv
bench/axil_slave_model.sv
bench/tb_rdma_reg_sequencer.sv
